/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f verilog.f --top-module tb_mycpu_top -o Vtb_mycpu_top

./obj_dir/Vtb_mycpu_top 2>&1 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"

/* source/alu.sv */
`default_nettype none
`timescale 1ns/10ps

module alu (
    input  wire la32_isa_pkg::alu_op_t   alu_op,
    input  wire la32_isa_pkg::word_t     alu_src1,
    input  wire la32_isa_pkg::word_t     alu_src2,
    output la32_isa_pkg::word_t          alu_result
);
    la32_isa_pkg::word_t add_res;
    la32_isa_pkg::word_t sub_res;
    la32_isa_pkg::word_t slt_res;
    la32_isa_pkg::word_t sltu_res;
    la32_isa_pkg::word_t sra_res;
    logic [4:0]          shamt;

    assign shamt    = alu_src2[4:0];
    assign add_res  = alu_src1 + alu_src2;
    assign sub_res  = alu_src1 - alu_src2;
    assign slt_res  = {31'b0, $signed(alu_src1) < $signed(alu_src2)};
    assign sltu_res = {31'b0, alu_src1 < alu_src2};
    assign sra_res  = $signed(alu_src1) >>> shamt;

    // One-hot select.
    assign alu_result =
          ({32{alu_op[la32_isa_pkg::ALU_ADD]}}  & add_res)
        | ({32{alu_op[la32_isa_pkg::ALU_SUB]}}  & sub_res)
        | ({32{alu_op[la32_isa_pkg::ALU_SLT]}}  & slt_res)
        | ({32{alu_op[la32_isa_pkg::ALU_SLTU]}} & sltu_res)
        | ({32{alu_op[la32_isa_pkg::ALU_AND]}}  & (alu_src1 & alu_src2))
        | ({32{alu_op[la32_isa_pkg::ALU_NOR]}}  & ~(alu_src1 | alu_src2))
        | ({32{alu_op[la32_isa_pkg::ALU_OR]}}   & (alu_src1 | alu_src2))
        | ({32{alu_op[la32_isa_pkg::ALU_XOR]}}  & (alu_src1 ^ alu_src2))
        | ({32{alu_op[la32_isa_pkg::ALU_SLL]}}  & (alu_src1 << shamt))
        | ({32{alu_op[la32_isa_pkg::ALU_SRL]}}  & (alu_src1 >> shamt))
        | ({32{alu_op[la32_isa_pkg::ALU_SRA]}}  & sra_res)
        | ({32{alu_op[la32_isa_pkg::ALU_LUI]}}  & alu_src2);

    // Decoder must never raise two operations at once.
    always_comb begin
        assert final ($onehot0(alu_op))
            else $error("alu_op not one-hot: %b", alu_op);
    end

endmodule

`default_nettype wire

/* source/core_ctrl_pkg.sv */
`default_nettype none

package core_ctrl_pkg;

    // One state per phase of an instruction.
    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4
    } ctrl_state_t;

    localparam int TRACE_WE_W = 4;

endpackage

`default_nettype wire

/* source/fetch_unit.sv */
`default_nettype none
`timescale 1ns/10ps

module fetch_unit #(
    parameter la32_isa_pkg::word_t RESET_PC = 32'h1c000000
) (
    input  wire                               clk,
    input  wire                               reset,
    input  wire core_ctrl_pkg::ctrl_state_t   state,
    input  wire la32_isa_pkg::word_t          inst_sram_rdata,
    input  wire la32_isa_pkg::word_t          rj_value,
    input  wire la32_isa_pkg::word_t          rkd_value,
    input  wire la32_isa_pkg::word_t          br_offs,
    input  wire la32_isa_pkg::word_t          jirl_offs,
    input  wire la32_isa_pkg::word_t          imm,
    input  wire [1:0]                         br_kind,
    input  wire                               br_from_reg,
    input  wire                               src1_is_pc,
    input  wire                               src2_is_imm,
    output la32_isa_pkg::word_t               inst_sram_addr,
    output la32_isa_pkg::word_t               pc,
    output la32_isa_pkg::word_t               ir,
    output logic                              br_taken,
    output la32_isa_pkg::word_t               alu_src1,
    output la32_isa_pkg::word_t               alu_src2
);
    la32_isa_pkg::word_t br_target;
    la32_isa_pkg::word_t next_pc;
    logic                rj_eq_rd;

    assign inst_sram_addr = pc;

    assign rj_eq_rd = (rj_value == rkd_value);

    always_comb begin
        case (br_kind)
            la32_isa_pkg::BR_EQ:     br_taken = rj_eq_rd;
            la32_isa_pkg::BR_NE:     br_taken = !rj_eq_rd;
            la32_isa_pkg::BR_ALWAYS: br_taken = 1'b1;
            default:                 br_taken = 1'b0;
        endcase
    end

    // jirl jumps relative to rj, all others relative to the PC.
    assign br_target = br_from_reg ? rj_value + jirl_offs : pc + br_offs;
    assign next_pc   = br_taken ? br_target : pc + 32'd4;

    assign alu_src1 = src1_is_pc ? pc : rj_value;
    assign alu_src2 = src2_is_imm ? imm : rkd_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
            ir <= '0;
        end else begin
            if (state == core_ctrl_pkg::DECODE) begin
                ir <= inst_sram_rdata;
            end
            // Result and PC are captured downstream in the same edge.
            if (state == core_ctrl_pkg::EXECUTE) begin
                pc <= next_pc;
            end
        end
    end

endmodule

`default_nettype wire

/* source/inst_decoder.sv */
`default_nettype none
`timescale 1ns/10ps

module inst_decoder (
    input  wire la32_isa_pkg::word_t     ir,
    output la32_isa_pkg::alu_op_t        alu_op,
    output la32_isa_pkg::reg_idx_t       raddr1,
    output la32_isa_pkg::reg_idx_t       raddr2,
    output la32_isa_pkg::reg_idx_t       dest,
    output la32_isa_pkg::word_t          imm,
    output la32_isa_pkg::word_t          br_offs,
    output la32_isa_pkg::word_t          jirl_offs,
    output logic [1:0]                   br_kind,
    output logic                         br_from_reg,
    output logic                         src1_is_pc,
    output logic                         src2_is_imm,
    output logic                         is_branch_only,
    output logic                         is_mem,
    output logic                         is_load,
    output logic                         writes_reg
);
    la32_isa_pkg::reg_idx_t rd;
    la32_isa_pkg::reg_idx_t rj;
    la32_isa_pkg::reg_idx_t rk;
    logic [4:0]             funct;
    logic                   op_rr;
    logic                   op_sh;
    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic is_alu3r, is_shift, is_link;

    assign rd    = ir[la32_isa_pkg::RD_LSB +: 5];
    assign rj    = ir[la32_isa_pkg::RJ_LSB +: 5];
    assign rk    = ir[la32_isa_pkg::RK_LSB +: 5];
    assign funct = ir[19:15];

    // Three-register and shift-immediate groups share a 12-bit prefix.
    assign op_rr = (ir[31:20] == 12'h001);
    assign op_sh = (ir[31:20] == 12'h004);

    assign inst_add_w   = op_rr && funct == 5'h00;
    assign inst_sub_w   = op_rr && funct == 5'h02;
    assign inst_slt     = op_rr && funct == 5'h04;
    assign inst_sltu    = op_rr && funct == 5'h05;
    assign inst_nor     = op_rr && funct == 5'h08;
    assign inst_and     = op_rr && funct == 5'h09;
    assign inst_or      = op_rr && funct == 5'h0a;
    assign inst_xor     = op_rr && funct == 5'h0b;
    assign inst_slli_w  = op_sh && funct == 5'h01;
    assign inst_srli_w  = op_sh && funct == 5'h09;
    assign inst_srai_w  = op_sh && funct == 5'h11;
    assign inst_addi_w  = (ir[31:22] == 10'h00a);
    assign inst_ld_w    = (ir[31:22] == 10'h0a2);
    assign inst_st_w    = (ir[31:22] == 10'h0a6);
    assign inst_lu12i_w = (ir[31:25] == 7'h0a);
    assign inst_jirl    = (ir[31:26] == 6'h13);
    assign inst_b       = (ir[31:26] == 6'h14);
    assign inst_bl      = (ir[31:26] == 6'h15);
    assign inst_beq     = (ir[31:26] == 6'h16);
    assign inst_bne     = (ir[31:26] == 6'h17);

    assign is_alu3r = inst_add_w | inst_sub_w | inst_slt | inst_sltu
                    | inst_nor | inst_and | inst_or | inst_xor;
    assign is_shift = inst_slli_w | inst_srli_w | inst_srai_w;
    assign is_link  = inst_jirl | inst_bl;

    always_comb begin
        alu_op = '0;
        alu_op[la32_isa_pkg::ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                                       | is_link;
        alu_op[la32_isa_pkg::ALU_SUB]  = inst_sub_w;
        alu_op[la32_isa_pkg::ALU_SLT]  = inst_slt;
        alu_op[la32_isa_pkg::ALU_SLTU] = inst_sltu;
        alu_op[la32_isa_pkg::ALU_AND]  = inst_and;
        alu_op[la32_isa_pkg::ALU_NOR]  = inst_nor;
        alu_op[la32_isa_pkg::ALU_OR]   = inst_or;
        alu_op[la32_isa_pkg::ALU_XOR]  = inst_xor;
        alu_op[la32_isa_pkg::ALU_SLL]  = inst_slli_w;
        alu_op[la32_isa_pkg::ALU_SRL]  = inst_srli_w;
        alu_op[la32_isa_pkg::ALU_SRA]  = inst_srai_w;
        alu_op[la32_isa_pkg::ALU_LUI]  = inst_lu12i_w;
    end

    // Link instructions add 4 to the PC.
    always_comb begin
        if (is_link) begin
            imm = 32'd4;
        end else if (inst_lu12i_w) begin
            imm = {ir[24:5], 12'b0};
        end else if (is_shift) begin
            imm = {27'b0, ir[14:10]};
        end else begin
            imm = {{20{ir[21]}}, ir[21:10]};
        end
    end

    assign jirl_offs = {{14{ir[25]}}, ir[25:10], 2'b0};
    assign br_offs   = (inst_b | inst_bl) ? {{4{ir[9]}}, ir[9:0], ir[25:10], 2'b0}
                                          : jirl_offs;

    always_comb begin
        if (inst_beq) begin
            br_kind = la32_isa_pkg::BR_EQ;
        end else if (inst_bne) begin
            br_kind = la32_isa_pkg::BR_NE;
        end else if (inst_b | is_link) begin
            br_kind = la32_isa_pkg::BR_ALWAYS;
        end else begin
            br_kind = la32_isa_pkg::BR_NONE;
        end
    end

    assign br_from_reg    = inst_jirl;
    assign src1_is_pc     = is_link;
    assign src2_is_imm    = is_shift | inst_addi_w | inst_lu12i_w | inst_ld_w | inst_st_w
                          | is_link;
    assign is_branch_only = inst_b | inst_beq | inst_bne;
    assign is_mem         = inst_ld_w | inst_st_w;
    assign is_load        = inst_ld_w;
    assign writes_reg     = is_alu3r | is_shift | inst_addi_w | inst_lu12i_w | inst_ld_w
                          | is_link;

    assign raddr1 = rj;
    assign raddr2 = (inst_beq | inst_bne | inst_st_w) ? rd : rk;
    assign dest   = inst_bl ? 5'd1 : rd;

endmodule

`default_nettype wire

/* source/la32_isa_pkg.sv */
`default_nettype none

package la32_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] alu_op_t;

    // Register fields inside the instruction word.
    localparam int RD_LSB = 0;
    localparam int RJ_LSB = 5;
    localparam int RK_LSB = 10;

    // Bit positions in the one-hot ALU operation.
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // Branch kinds.
    localparam logic [1:0] BR_NONE   = 2'd0;
    localparam logic [1:0] BR_EQ     = 2'd1;
    localparam logic [1:0] BR_NE     = 2'd2;
    localparam logic [1:0] BR_ALWAYS = 2'd3;

endpackage

`default_nettype wire

/* source/mem_writeback.sv */
`default_nettype none
`timescale 1ns/10ps

module mem_writeback (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire core_ctrl_pkg::ctrl_state_t       state,
    input  wire la32_isa_pkg::word_t              alu_result,
    input  wire la32_isa_pkg::word_t              rkd_value,
    input  wire la32_isa_pkg::word_t              pc,
    input  wire la32_isa_pkg::reg_idx_t           dest,
    input  wire                                   is_mem,
    input  wire                                   is_load,
    input  wire                                   writes_reg,
    input  wire la32_isa_pkg::word_t              data_sram_rdata,
    output logic                                  data_sram_we,
    output la32_isa_pkg::word_t                   data_sram_addr,
    output la32_isa_pkg::word_t                   data_sram_wdata,
    output logic                                  rf_we,
    output la32_isa_pkg::reg_idx_t                rf_waddr,
    output la32_isa_pkg::word_t                   rf_wdata,
    output la32_isa_pkg::word_t                   debug_wb_pc,
    output logic [core_ctrl_pkg::TRACE_WE_W-1:0]  debug_wb_rf_we,
    output la32_isa_pkg::reg_idx_t                debug_wb_rf_wnum,
    output la32_isa_pkg::word_t                   debug_wb_rf_wdata
);
    la32_isa_pkg::word_t result_q;
    la32_isa_pkg::word_t store_q;
    la32_isa_pkg::word_t pc_q;

    // Hold the execute outputs for the later states.
    always_ff @(posedge clk) begin
        if (state == core_ctrl_pkg::EXECUTE) begin
            result_q <= alu_result;
            store_q  <= rkd_value;
            pc_q     <= pc;
        end
    end

    assign data_sram_we    = (state == core_ctrl_pkg::MEMORY) && is_mem && !is_load;
    assign data_sram_addr  = result_q;
    assign data_sram_wdata = store_q;

    // Load data arrives the cycle after MEMORY.
    assign rf_we    = (state == core_ctrl_pkg::WRITEBACK) && writes_reg;
    assign rf_waddr = dest;
    assign rf_wdata = is_load ? data_sram_rdata : result_q;

    assign debug_wb_pc       = pc_q;
    assign debug_wb_rf_we    = {core_ctrl_pkg::TRACE_WE_W{rf_we}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = rf_wdata;

    a_store_after_exec: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> $past(state) == core_ctrl_pkg::EXECUTE)
        else $error("data write not directly after EXECUTE");

    a_wb_after_exec_or_mem: assert property (@(posedge clk) disable iff (reset)
        rf_we |-> $past(state) inside {core_ctrl_pkg::EXECUTE, core_ctrl_pkg::MEMORY})
        else $error("register write outside WRITEBACK");

endmodule

`default_nettype wire

/* source/multicycle_control.sv */
`default_nettype none
`timescale 1ns/10ps

module multicycle_control (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           is_branch_only,
    input  wire                           is_mem,
    input  wire                           is_load,
    output core_ctrl_pkg::ctrl_state_t    state
);
    core_ctrl_pkg::ctrl_state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= core_ctrl_pkg::FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            core_ctrl_pkg::FETCH:   next_state = core_ctrl_pkg::DECODE;
            core_ctrl_pkg::DECODE:  next_state = core_ctrl_pkg::EXECUTE;
            core_ctrl_pkg::EXECUTE: begin
                if (is_branch_only) begin
                    next_state = core_ctrl_pkg::FETCH;
                end else if (is_mem) begin
                    next_state = core_ctrl_pkg::MEMORY;
                end else begin
                    next_state = core_ctrl_pkg::WRITEBACK;
                end
            end
            // Only loads carry on to write-back.
            core_ctrl_pkg::MEMORY:
                next_state = is_load ? core_ctrl_pkg::WRITEBACK : core_ctrl_pkg::FETCH;
            default: next_state = core_ctrl_pkg::FETCH;
        endcase
    end

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {core_ctrl_pkg::FETCH, core_ctrl_pkg::DECODE, core_ctrl_pkg::EXECUTE,
                      core_ctrl_pkg::MEMORY, core_ctrl_pkg::WRITEBACK})
        else $error("controller left its state set: %0d", state);

endmodule

`default_nettype wire

/* source/mycpu_top.sv */
`default_nettype none
`timescale 1ns/10ps

module mycpu_top #(
    parameter la32_isa_pkg::word_t RESET_PC = 32'h1c000000
) (
    input  wire                                   clk,
    input  wire                                   reset,
    output logic                                  inst_sram_we,
    output la32_isa_pkg::word_t                   inst_sram_addr,
    output la32_isa_pkg::word_t                   inst_sram_wdata,
    input  wire la32_isa_pkg::word_t              inst_sram_rdata,
    output logic                                  data_sram_we,
    output la32_isa_pkg::word_t                   data_sram_addr,
    output la32_isa_pkg::word_t                   data_sram_wdata,
    input  wire la32_isa_pkg::word_t              data_sram_rdata,
    output la32_isa_pkg::word_t                   debug_wb_pc,
    output logic [core_ctrl_pkg::TRACE_WE_W-1:0]  debug_wb_rf_we,
    output la32_isa_pkg::reg_idx_t                debug_wb_rf_wnum,
    output la32_isa_pkg::word_t                   debug_wb_rf_wdata
);
    core_ctrl_pkg::ctrl_state_t state;
    la32_isa_pkg::word_t    pc, ir, imm, br_offs, jirl_offs;
    la32_isa_pkg::word_t    rj_value, rkd_value, alu_src1, alu_src2, alu_result;
    la32_isa_pkg::word_t    rf_wdata;
    la32_isa_pkg::reg_idx_t raddr1, raddr2, dest, rf_waddr;
    la32_isa_pkg::alu_op_t  alu_op;
    logic [1:0]             br_kind;
    logic br_from_reg, src1_is_pc, src2_is_imm;
    logic is_branch_only, is_mem, is_load, writes_reg, rf_we;

    // Instruction memory is read-only.
    assign inst_sram_we    = 1'b0;
    assign inst_sram_wdata = '0;

    multicycle_control u_ctrl (
        .clk(clk), .reset(reset), .is_branch_only(is_branch_only),
        .is_mem(is_mem), .is_load(is_load), .state(state)
    );

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .reset(reset), .state(state), .inst_sram_rdata(inst_sram_rdata),
        .rj_value(rj_value), .rkd_value(rkd_value), .br_offs(br_offs),
        .jirl_offs(jirl_offs), .imm(imm), .br_kind(br_kind), .br_from_reg(br_from_reg),
        .src1_is_pc(src1_is_pc), .src2_is_imm(src2_is_imm),
        .inst_sram_addr(inst_sram_addr), .pc(pc), .ir(ir), .br_taken(),
        .alu_src1(alu_src1), .alu_src2(alu_src2)
    );

    inst_decoder u_dec (
        .ir(ir), .alu_op(alu_op), .raddr1(raddr1), .raddr2(raddr2), .dest(dest),
        .imm(imm), .br_offs(br_offs), .jirl_offs(jirl_offs), .br_kind(br_kind),
        .br_from_reg(br_from_reg), .src1_is_pc(src1_is_pc), .src2_is_imm(src2_is_imm),
        .is_branch_only(is_branch_only), .is_mem(is_mem), .is_load(is_load),
        .writes_reg(writes_reg)
    );

    reg_file u_rf (
        .clk(clk), .raddr1(raddr1), .raddr2(raddr2), .we(rf_we), .waddr(rf_waddr),
        .wdata(rf_wdata), .rdata1(rj_value), .rdata2(rkd_value)
    );

    alu u_alu (
        .alu_op(alu_op), .alu_src1(alu_src1), .alu_src2(alu_src2), .alu_result(alu_result)
    );

    mem_writeback u_mwb (
        .clk(clk), .reset(reset), .state(state), .alu_result(alu_result),
        .rkd_value(rkd_value), .pc(pc), .dest(dest), .is_mem(is_mem), .is_load(is_load),
        .writes_reg(writes_reg), .data_sram_rdata(data_sram_rdata),
        .data_sram_we(data_sram_we), .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata), .rf_we(rf_we), .rf_waddr(rf_waddr),
        .rf_wdata(rf_wdata), .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

/* source/reg_file.sv */
`default_nettype none
`timescale 1ns/10ps

module reg_file (
    input  wire                             clk,
    input  wire la32_isa_pkg::reg_idx_t     raddr1,
    input  wire la32_isa_pkg::reg_idx_t     raddr2,
    input  wire                             we,
    input  wire la32_isa_pkg::reg_idx_t     waddr,
    input  wire la32_isa_pkg::word_t        wdata,
    output la32_isa_pkg::word_t             rdata1,
    output la32_isa_pkg::word_t             rdata2
);
    la32_isa_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* verification/tb_mycpu_top.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_mycpu_top;

    localparam logic [31:0] RESET_PC = 32'h1c000000;
    localparam int CLK_PERIOD = 40;
    localparam int N_ENTRIES = 36;
    localparam int WATCHDOG_NS = N_ENTRIES * 5 * CLK_PERIOD + 50 * CLK_PERIOD;

    // Entry kinds. A skipped entry must never be executed.
    localparam int KIND_NONE = 0;
    localparam int KIND_WRITE = 1;
    localparam int KIND_STORE = 2;
    localparam int KIND_SKIP = 3;

    // Opcode bits with all register and immediate fields zero.
    localparam logic [31:0] OP_ADD = 32'h00100000;
    localparam logic [31:0] OP_SUB = 32'h00110000;
    localparam logic [31:0] OP_SLT = 32'h00120000;
    localparam logic [31:0] OP_SLTU = 32'h00128000;
    localparam logic [31:0] OP_NOR = 32'h00140000;
    localparam logic [31:0] OP_AND = 32'h00148000;
    localparam logic [31:0] OP_OR = 32'h00150000;
    localparam logic [31:0] OP_XOR = 32'h00158000;
    localparam logic [31:0] OP_SLLI = 32'h00408000;
    localparam logic [31:0] OP_SRLI = 32'h00448000;
    localparam logic [31:0] OP_SRAI = 32'h00488000;
    localparam logic [31:0] OP_ADDI = 32'h02800000;
    localparam logic [31:0] OP_LU12I = 32'h14000000;
    localparam logic [31:0] OP_LD = 32'h28800000;
    localparam logic [31:0] OP_ST = 32'h29800000;
    localparam logic [31:0] OP_JIRL = 32'h4c000000;
    localparam logic [31:0] OP_B = 32'h50000000;
    localparam logic [31:0] OP_BL = 32'h54000000;
    localparam logic [31:0] OP_BEQ = 32'h58000000;
    localparam logic [31:0] OP_BNE = 32'h5c000000;

    localparam logic [31:0] LOAD_ADDR = 32'h00000040;

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_rdata = '0;
    logic [31:0] data_sram_rdata = '0;
    logic        inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] dmem_init [256];

    logic [31:0] tbl_inst [N_ENTRIES];
    int          tbl_kind [N_ENTRIES];
    logic [4:0]  tbl_reg [N_ENTRIES];
    logic [31:0] tbl_val [N_ENTRIES];
    logic [31:0] tbl_addr [N_ENTRIES];
    int          tbl_n;

    int   write_idx [$];
    int   store_idx [$];
    int   n_writes;
    int   n_stores;
    int   writes_seen = 0;
    int   stores_seen = 0;
    int   errors = 0;
    logic first_fetch_seen = 1'b0;

    mycpu_top #(.RESET_PC(RESET_PC)) dut (
        .clk(clk), .reset(reset),
        .inst_sram_we(inst_sram_we), .inst_sram_addr(inst_sram_addr),
        .inst_sram_wdata(inst_sram_wdata), .inst_sram_rdata(inst_sram_rdata),
        .data_sram_we(data_sram_we), .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata), .data_sram_rdata(data_sram_rdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    function automatic logic [31:0] pc_of(input int i);
        return RESET_PC + 4 * i;
    endfunction

    function automatic logic [31:0] rrr_word(input logic [31:0] base, input logic [4:0] rd,
                                             input logic [4:0] rj, input logic [4:0] rk);
        return base | {17'b0, rk, rj, rd};
    endfunction

    function automatic logic [31:0] ri12_word(input logic [31:0] base, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [11:0] si12);
        return base | {10'b0, si12, rj, rd};
    endfunction

    function automatic logic [31:0] ri20_word(input logic [31:0] base, input logic [4:0] rd,
                                              input logic [19:0] si20);
        return base | {7'b0, si20, rd};
    endfunction

    // Branch offsets count words.
    function automatic logic [31:0] ri16_word(input logic [31:0] base, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [15:0] offs);
        return base | {6'b0, offs, rj, rd};
    endfunction

    function automatic logic [31:0] i26_word(input logic [31:0] base, input logic [25:0] offs);
        return base | {6'b0, offs[15:0], offs[25:16]};
    endfunction

    task automatic write_entry(input logic [31:0] inst, input logic [4:0] rnum,
                               input logic [31:0] val);
        tbl_inst[tbl_n] = inst;
        tbl_kind[tbl_n] = KIND_WRITE;
        tbl_reg[tbl_n] = rnum;
        tbl_val[tbl_n] = val;
        tbl_n++;
    endtask

    task automatic store_entry(input logic [31:0] inst, input logic [31:0] addr,
                               input logic [31:0] val);
        tbl_inst[tbl_n] = inst;
        tbl_kind[tbl_n] = KIND_STORE;
        tbl_addr[tbl_n] = addr;
        tbl_val[tbl_n] = val;
        tbl_n++;
    endtask

    task automatic plain_entry(input logic [31:0] inst, input int kind);
        tbl_inst[tbl_n] = inst;
        tbl_kind[tbl_n] = kind;
        tbl_n++;
    endtask

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        a = 32'h12345000 + 32'h00000678;
        b = 32'hfedcb000 + 32'hffffffff;
        tbl_n = 0;
        write_entry(ri20_word(OP_LU12I, 5'd4, 20'h12345), 5'd4, 32'h12345000);
        write_entry(ri12_word(OP_ADDI, 5'd4, 5'd4, 12'h678), 5'd4, a);
        write_entry(ri20_word(OP_LU12I, 5'd5, 20'hfedcb), 5'd5, 32'hfedcb000);
        write_entry(ri12_word(OP_ADDI, 5'd5, 5'd5, 12'hfff), 5'd5, b);
        write_entry(rrr_word(OP_ADD, 5'd6, 5'd4, 5'd5), 5'd6, a + b);
        write_entry(rrr_word(OP_SUB, 5'd7, 5'd4, 5'd5), 5'd7, a - b);
        // b is negative, so b < a signed but not unsigned.
        write_entry(rrr_word(OP_SLT, 5'd8, 5'd5, 5'd4), 5'd8, 32'd1);
        write_entry(rrr_word(OP_SLTU, 5'd9, 5'd4, 5'd5), 5'd9, 32'd1);
        write_entry(rrr_word(OP_AND, 5'd10, 5'd4, 5'd5), 5'd10, a & b);
        write_entry(rrr_word(OP_NOR, 5'd11, 5'd4, 5'd5), 5'd11, ~(a | b));
        write_entry(rrr_word(OP_OR, 5'd12, 5'd4, 5'd5), 5'd12, a | b);
        write_entry(rrr_word(OP_XOR, 5'd13, 5'd4, 5'd5), 5'd13, a ^ b);
        write_entry(ri12_word(OP_SLLI, 5'd14, 5'd4, 12'd4), 5'd14, a << 4);
        write_entry(ri12_word(OP_SRLI, 5'd15, 5'd5, 12'd8), 5'd15, b >> 8);
        write_entry(ri12_word(OP_SRAI, 5'd16, 5'd5, 12'd8), 5'd16, {{8{b[31]}}, b[31:8]});
        write_entry(ri12_word(OP_ADDI, 5'd20, 5'd0, 12'h200), 5'd20, 32'h200);
        store_entry(ri12_word(OP_ST, 5'd4, 5'd20, 12'h010), 32'h210, a);
        write_entry(ri12_word(OP_LD, 5'd17, 5'd20, 12'h010), 5'd17, a);
        write_entry(ri12_word(OP_LD, 5'd18, 5'd0, LOAD_ADDR[11:0]), 5'd18,
                    dmem_init[LOAD_ADDR[9:2]]);
        plain_entry(ri16_word(OP_BEQ, 5'd5, 5'd4, 16'd2), KIND_NONE);
        write_entry(ri12_word(OP_ADDI, 5'd19, 5'd0, 12'd1), 5'd19, 32'd1);
        plain_entry(ri16_word(OP_BNE, 5'd5, 5'd4, 16'd2), KIND_NONE);
        plain_entry(ri12_word(OP_ADDI, 5'd19, 5'd0, 12'd2), KIND_SKIP);
        plain_entry(ri16_word(OP_BEQ, 5'd4, 5'd17, 16'd2), KIND_NONE);
        plain_entry(ri12_word(OP_ADDI, 5'd19, 5'd0, 12'd3), KIND_SKIP);
        plain_entry(ri16_word(OP_BNE, 5'd4, 5'd17, 16'd2), KIND_NONE);
        write_entry(ri12_word(OP_ADDI, 5'd21, 5'd0, 12'd5), 5'd21, 32'd5);
        plain_entry(i26_word(OP_B, 26'd2), KIND_NONE);
        plain_entry(ri12_word(OP_ADDI, 5'd21, 5'd0, 12'd6), KIND_SKIP);
        write_entry(i26_word(OP_BL, 26'd3), 5'd1, pc_of(tbl_n) + 32'd4);
        plain_entry(ri12_word(OP_ADDI, 5'd22, 5'd0, 12'd7), KIND_SKIP);
        plain_entry(ri12_word(OP_ADDI, 5'd22, 5'd0, 12'd8), KIND_SKIP);
        // r1 points two entries back, so this lands two past the jirl.
        write_entry(ri16_word(OP_JIRL, 5'd23, 5'd1, 16'd4), 5'd23, pc_of(tbl_n) + 32'd4);
        plain_entry(ri12_word(OP_ADDI, 5'd22, 5'd0, 12'd8), KIND_SKIP);
        write_entry(ri12_word(OP_ADDI, 5'd22, 5'd0, 12'd9), 5'd22, 32'd9);
        plain_entry(i26_word(OP_B, 26'd0), KIND_NONE);
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        errors++;
    endtask

    task automatic compare_trace();
        int          i;
        logic [31:0] exp_pc;
        if (write_idx.size() == 0) begin
            $display("Unexpected register write to r%0d at %0t ns", debug_wb_rf_wnum, $time);
            errors++;
        end else begin
            i = write_idx.pop_front();
            exp_pc = pc_of(i);
            if (debug_wb_rf_we != 4'hf) begin
                report_mismatch("trace write enable", {28'b0, debug_wb_rf_we}, 32'hf);
            end
            if (debug_wb_pc != exp_pc) begin
                report_mismatch("trace pc", debug_wb_pc, exp_pc);
            end
            if (debug_wb_rf_wnum != tbl_reg[i]) begin
                report_mismatch("trace register", {27'b0, debug_wb_rf_wnum}, {27'b0, tbl_reg[i]});
            end
            if (debug_wb_rf_wdata != tbl_val[i]) begin
                report_mismatch("trace data", debug_wb_rf_wdata, tbl_val[i]);
            end
            writes_seen++;
        end
    endtask

    task automatic verify_store();
        int i;
        if (store_idx.size() == 0) begin
            $display("Unexpected data SRAM write to %h at %0t ns", data_sram_addr, $time);
            errors++;
        end else begin
            i = store_idx.pop_front();
            if (data_sram_addr != tbl_addr[i]) begin
                report_mismatch("store address", data_sram_addr, tbl_addr[i]);
            end
            if (data_sram_wdata != tbl_val[i]) begin
                report_mismatch("store data", data_sram_wdata, tbl_val[i]);
            end
            stores_seen++;
        end
    endtask

    task automatic finish_run(input logic timed_out);
        if (timed_out) begin
            $display("Timeout: program did not complete within %0d ns", WATCHDOG_NS);
        end
        $display("Checked %0d of %0d register writes and %0d of %0d stores, %0d errors",
                 writes_seen, n_writes, stores_seen, n_stores, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Both SRAMs answer one cycle after the address. Data SRAM reloads during reset.
    always @(posedge clk) begin
        inst_sram_rdata <= imem[inst_sram_addr[9:2]];
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= dmem_init[i];
            end
        end else if (data_sram_we) begin
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        end
        data_sram_rdata <= dmem[data_sram_addr[9:2]];
    end

    always @(negedge clk) begin
        if (inst_sram_we !== 1'b0) begin
            $display("Instruction SRAM write enable raised at %0t ns", $time);
            errors++;
        end
        if (inst_sram_wdata !== '0) begin
            $display("Instruction SRAM write data not tied off at %0t ns", $time);
            errors++;
        end
        if (reset) begin
            if (data_sram_we || debug_wb_rf_we != '0) begin
                $display("Write strobe active during reset at %0t ns", $time);
                errors++;
            end
        end else begin
            if (!first_fetch_seen) begin
                first_fetch_seen = 1'b1;
                if (inst_sram_addr != RESET_PC) begin
                    report_mismatch("first fetch address", inst_sram_addr, RESET_PC);
                end
            end
            if (debug_wb_rf_we != '0) begin
                compare_trace();
            end
            if (data_sram_we) begin
                verify_store();
            end
        end
    end

    initial begin
        reset <= 1'b1;
        void'($urandom(78));
        for (int i = 0; i < 256; i++) begin
            dmem_init[i] = $urandom;
            imem[i] = '0;
        end
        build_program();
        for (int i = 0; i < N_ENTRIES; i++) begin
            imem[i] = tbl_inst[i];
            if (tbl_kind[i] == KIND_WRITE) begin
                write_idx.push_back(i);
            end
            if (tbl_kind[i] == KIND_STORE) begin
                store_idx.push_back(i);
            end
        end
        n_writes = write_idx.size();
        n_stores = store_idx.size();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        wait (writes_seen == n_writes && stores_seen == n_stores);
        // The closing branch spins in place, so no further writes may show.
        repeat (10) @(posedge clk);
        finish_run(1'b0);
    end

    initial begin
        #(WATCHDOG_NS);
        finish_run(1'b1);
    end

endmodule

`default_nettype wire

/* verilog.f */
source/la32_isa_pkg.sv
source/core_ctrl_pkg.sv
source/fetch_unit.sv
source/inst_decoder.sv
source/reg_file.sv
source/alu.sv
source/multicycle_control.sv
source/mem_writeback.sv
source/mycpu_top.sv
verification/tb_mycpu_top.sv
